// ==== filelist.f ====
demod_pkg.sv
flow_pkg.sv
qpsk_demap.sv
llr_fifo.sv
demod_top.sv
demod_tb.sv

// ==== demod_tb.sv ====
`timescale 1ns/1ns

// Testbench for the QPSK soft demapping stage.
// A random source sends symbols under input credits and a random sink takes the
// beats and hands back output credits. Every symbol is turned into two expected
// beats in a queue, and each beat coming out of the DUT is compared with it.
module demod_tb;

    import demod_pkg::*;
    import flow_pkg::*;

    localparam int IQ_DW       = IQ_DW_DEFAULT;
    localparam int LLR_DW      = LLR_DW_DEFAULT;
    localparam int FIFO_DEPTH  = FIFO_DEPTH_DEFAULT;
    localparam int OUT_CREDITS = OUT_CREDITS_DEFAULT;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 10;
    localparam int IDLE_CYCLES  = 12;
    localparam int N_RANDOM     = 300;
    localparam int FILL_BUDGET  = 2 * FIFO_DEPTH;
    localparam int HOLD_CYCLES  = 4 * FIFO_DEPTH;

    // A symbol needs two beats and each beat may wait a while for a random credit
    localparam int CYCLES_PER_SYMBOL = 40;
    localparam int MAX_CYCLES = RESET_CYCLES + IDLE_CYCLES + HOLD_CYCLES
                              + (N_RANDOM + FILL_BUDGET) * CYCLES_PER_SYMBOL;

    // One expected output beat
    typedef struct packed {
        logic              is_q;
        logic              last;
        logic [TAG_W-1:0]  tag;
        logic [LLR_DW-1:0] llr;
    } beat_t;

    logic                     clk_i;
    logic                     reset_ni;
    logic                     in_valid;
    logic signed [IQ_DW-1:0]  in_i;
    logic signed [IQ_DW-1:0]  in_q;
    logic [TAG_W-1:0]         in_tag;
    logic                     in_last;
    logic                     in_credit;
    logic                     out_valid;
    logic signed [LLR_DW-1:0] out_llr;
    logic [TAG_W-1:0]         out_tag;
    logic                     out_last;
    logic                     credit_return;

    integer seed;
    beat_t  exp_q[$];

    // Source state, all owned by the clocked process
    int sent_total;
    int src_credits;
    int in_credit_total;

    // Sink state, outstanding is the number of beats the sink still holds
    int outstanding;
    int beats_rx;

    // Knobs set by the test sequence on the falling edge
    int send_target;
    int send_rate;
    int sink_rate;
    bit release_en;
    bit checks_on;

    int err_count;
    int test_count;

    demod_top #(
        .IQ_DW       (IQ_DW),
        .LLR_DW      (LLR_DW),
        .FIFO_DEPTH  (FIFO_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) UUT (
        .clk_i         (clk_i),
        .reset_ni      (reset_ni),
        .in_valid      (in_valid),
        .in_i          (in_i),
        .in_q          (in_q),
        .in_tag        (in_tag),
        .in_last       (in_last),
        .in_credit     (in_credit),
        .out_valid     (out_valid),
        .out_llr       (out_llr),
        .out_tag       (out_tag),
        .out_last      (out_last),
        .credit_return (credit_return)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // The LLR is the sample scaled down to LLR_DW bits, sign kept
    function automatic logic [LLR_DW-1:0] top_bits(input logic signed [IQ_DW-1:0] s);
        logic signed [IQ_DW-1:0] scaled;
        scaled = s >>> (IQ_DW - LLR_DW);
        return scaled[LLR_DW-1:0];
    endfunction

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
        $display("ERR %0t %s got %0h expected %0h", $time, name, got, expected);
        err_count++;
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_count++;
        $display("test %s finished with %0d error(s)", name, err_count - errs_before);
    endtask

    // Compare the beat seen at this edge and the input credit that goes with it
    task automatic check_beat();
        beat_t exp_beat;
        logic  exp_credit;
        exp_credit = 1'b0;
        if (out_valid === 1'b1) begin
            // The sink has room for OUT_CREDITS beats and no more
            assert (outstanding < OUT_CREDITS) else begin
                $display("Beat at %0t sent while all %0d sink slots were taken",
                         $time, OUT_CREDITS);
                err_count++;
            end
            assert (exp_q.size() != 0) else begin
                $display("Beat at %0t arrived with no symbol left to send", $time);
                err_count++;
            end
            if (exp_q.size() != 0) begin
                exp_beat   = exp_q.pop_front();
                exp_credit = exp_beat.is_q;
                assert (out_llr === exp_beat.llr) else
                    report_value("out_llr", $unsigned(out_llr), exp_beat.llr);
                assert (out_tag === exp_beat.tag) else
                    report_value("out_tag", out_tag, exp_beat.tag);
                assert (out_last === exp_beat.last) else
                    report_value("out_last", out_last, exp_beat.last);
            end
        end else begin
            assert (out_valid === 1'b0) else
                report_value("out_valid", out_valid, 0);
        end
        // A slot is freed exactly when its Q beat leaves
        assert (in_credit === exp_credit) else
            report_value("in_credit", in_credit, exp_credit);
    endtask

    // Values sampled here are the ones the DUT acts on at this same edge
    task automatic update_counts();
        if (out_valid === 1'b1) begin
            outstanding++;
            beats_rx++;
        end
        if (credit_return) begin
            outstanding--;
        end
        if (in_credit === 1'b1) begin
            src_credits++;
            in_credit_total++;
        end
    endtask

    task automatic drive_source();
        logic signed [IQ_DW-1:0] s_i;
        logic signed [IQ_DW-1:0] s_q;
        logic [TAG_W-1:0]        tag;
        logic                    last;
        beat_t                   b;
        int                      pct;
        pct = $unsigned($random(seed)) % 100;
        if (sent_total < send_target && src_credits > 0 && pct < send_rate) begin
            s_i  = $random(seed);
            s_q  = $random(seed);
            tag  = $random(seed);
            last = (($random(seed) & 7) == 0);
            // I beat carries the tag only, Q beat adds the frame marker
            b.is_q = 1'b0;
            b.last = 1'b0;
            b.tag  = tag;
            b.llr  = top_bits(s_i);
            exp_q.push_back(b);
            b.is_q = 1'b1;
            b.last = last;
            b.llr  = top_bits(s_q);
            exp_q.push_back(b);
            src_credits--;
            sent_total++;
            in_valid <= 1'b1;
            in_i     <= s_i;
            in_q     <= s_q;
            in_tag   <= tag;
            in_last  <= last;
        end else begin
            in_valid <= 1'b0;
        end
    endtask

    // A return pulse is only raised for a beat the sink really holds
    task automatic drive_sink();
        int pct;
        pct = $unsigned($random(seed)) % 100;
        if (release_en && outstanding > 0 && pct < sink_rate) begin
            credit_return <= 1'b1;
        end else begin
            credit_return <= 1'b0;
        end
    endtask

    always @(posedge clk_i) begin
        if (checks_on) begin
            check_beat();
            update_counts();
            drive_source();
            drive_sink();
        end
    end

    // Waits until every symbol of the current target has left the DUT
    task automatic wait_drained();
        while (sent_total < send_target || exp_q.size() != 0) begin
            @(negedge clk_i);
        end
        while (outstanding != 0 || credit_return) begin
            @(negedge clk_i);
        end
    endtask

    initial begin : watchdog
        #(MAX_CYCLES * CLK_PERIOD);
        $display("Timeout after %0d cycles, the run did not finish", MAX_CYCLES);
        $display("Errors found");
        $finish;
    end

    initial begin
        int errs_before;
        int sent0;
        int rx0;
        int cr0;
        clk_i           = 1'b0;
        reset_ni        = 1'b0;
        in_valid        = 1'b0;
        in_i            = '0;
        in_q            = '0;
        in_tag          = '0;
        in_last         = 1'b0;
        credit_return   = 1'b0;
        seed            = 88;
        sent_total      = 0;
        src_credits     = FIFO_DEPTH;
        in_credit_total = 0;
        outstanding     = 0;
        beats_rx        = 0;
        send_target     = 0;
        send_rate       = 0;
        sink_rate       = 0;
        release_en      = 1'b0;
        checks_on       = 1'b0;
        err_count       = 0;
        test_count      = 0;

        repeat (RESET_CYCLES) @(posedge clk_i);
        reset_ni <= 1'b1;
        @(negedge clk_i);
        checks_on = 1'b1;

        // Nothing may come out before the first symbol goes in
        errs_before = err_count;
        repeat (IDLE_CYCLES) begin
            @(negedge clk_i);
            assert (out_valid === 1'b0) else report_value("out_valid", out_valid, 0);
            assert (in_credit === 1'b0) else report_value("in_credit", in_credit, 0);
        end
        report_test("reset_state", errs_before);

        // Random traffic on both sides
        errs_before = err_count;
        rx0         = beats_rx;
        send_rate   = 60;
        sink_rate   = 50;
        release_en  = 1'b1;
        send_target = sent_total + N_RANDOM;
        wait_drained();
        assert (beats_rx - rx0 == 2 * N_RANDOM) else
            report_value("beats received", beats_rx - rx0, 2 * N_RANDOM);
        report_test("random_traffic", errs_before);

        // Sink withholds credits, so only OUT_CREDITS beats can leave
        // and the source stalls once the buffer is full
        errs_before = err_count;
        assert (src_credits == FIFO_DEPTH) else
            report_value("source credits", src_credits, FIFO_DEPTH);
        sent0       = sent_total;
        rx0         = beats_rx;
        cr0         = in_credit_total;
        release_en  = 1'b0;
        send_rate   = 100;
        send_target = sent_total + FILL_BUDGET;
        repeat (HOLD_CYCLES) @(negedge clk_i);
        assert (beats_rx - rx0 == OUT_CREDITS) else
            report_value("beats received", beats_rx - rx0, OUT_CREDITS);
        assert (in_credit_total - cr0 == OUT_CREDITS / 2) else
            report_value("in_credit pulses", in_credit_total - cr0, OUT_CREDITS / 2);
        assert (sent_total - sent0 == FIFO_DEPTH + OUT_CREDITS / 2) else
            report_value("symbols sent", sent_total - sent0, FIFO_DEPTH + OUT_CREDITS / 2);
        assert (src_credits == 0) else
            report_value("source credits", src_credits, 0);
        // Release the sink and let every buffered symbol drain
        release_en = 1'b1;
        sink_rate  = 50;
        wait_drained();
        report_test("fill_and_hold", errs_before);

        // One input credit per symbol over the whole run
        errs_before = err_count;
        assert (in_credit_total == sent_total) else
            report_value("in_credit pulses", in_credit_total, sent_total);
        assert (src_credits == FIFO_DEPTH) else
            report_value("source credits", src_credits, FIFO_DEPTH);
        report_test("credit_totals", errs_before);

        $display("%0d tests run, %0d symbols sent, %0d errors",
                 test_count, sent_total, err_count);
        if (err_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== demod_top.sv ====
`timescale 1ns/1ns

// Soft-decision QPSK demapping stage.
// Symbols come in as I/Q pairs under input credits.
// LLRs go out as two serial beats per symbol under output credits.
module demod_top #(
    parameter int IQ_DW       = demod_pkg::IQ_DW_DEFAULT,
    parameter int LLR_DW      = demod_pkg::LLR_DW_DEFAULT,
    parameter int FIFO_DEPTH  = flow_pkg::FIFO_DEPTH_DEFAULT,
    parameter int OUT_CREDITS = flow_pkg::OUT_CREDITS_DEFAULT
) (
    input  logic                           clk_i,
    input  logic                           reset_ni,

    // Input side, the source starts with FIFO_DEPTH credits
    input  logic                           in_valid,
    input  logic signed [IQ_DW-1:0]        in_i,
    input  logic signed [IQ_DW-1:0]        in_q,
    input  logic [demod_pkg::TAG_W-1:0]    in_tag,
    input  logic                           in_last,
    output logic                           in_credit,

    // Output side, the sink returns one credit per consumed beat
    output logic                           out_valid,
    output logic signed [LLR_DW-1:0]       out_llr,
    output logic [demod_pkg::TAG_W-1:0]    out_tag,
    output logic                           out_last,
    input  logic                           credit_return
);

    import demod_pkg::*;

    // LLR pair between demapper and buffer
    logic                     pair_valid;
    logic signed [LLR_DW-1:0] pair_llr_i;
    logic signed [LLR_DW-1:0] pair_llr_q;
    logic [TAG_W-1:0]         pair_tag;
    logic                     pair_last;

    // Slices each symbol into its LLR pair, one cycle latency
    qpsk_demap #(
        .IQ_DW  (IQ_DW),
        .LLR_DW (LLR_DW)
    ) u_demap (
        .clk_i      (clk_i),
        .reset_ni   (reset_ni),
        .in_valid   (in_valid),
        .in_i       (in_i),
        .in_q       (in_q),
        .in_tag     (in_tag),
        .in_last    (in_last),
        .pair_valid (pair_valid),
        .pair_llr_i (pair_llr_i),
        .pair_llr_q (pair_llr_q),
        .pair_tag   (pair_tag),
        .pair_last  (pair_last)
    );

    // Holds pairs and plays them out as I then Q beats
    // Its depth sets how many input credits the source may hold
    llr_fifo #(
        .LLR_DW      (LLR_DW),
        .FIFO_DEPTH  (FIFO_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) u_fifo (
        .clk_i         (clk_i),
        .reset_ni      (reset_ni),
        .pair_valid    (pair_valid),
        .pair_llr_i    (pair_llr_i),
        .pair_llr_q    (pair_llr_q),
        .pair_tag      (pair_tag),
        .pair_last     (pair_last),
        .credit_return (credit_return),
        .in_credit     (in_credit),
        .out_valid     (out_valid),
        .out_llr       (out_llr),
        .out_tag       (out_tag),
        .out_last      (out_last)
    );

endmodule

// ==== llr_fifo.sv ====
`timescale 1ns/1ns

// Buffer and serializer for LLR pairs.
// Pairs are stored whole and sent as two beats, I first and Q second.
// Both beats carry the tag, the Q beat alone carries the frame marker.
// The output side spends one credit per beat and regains one per credit_return.
// The input side gets a credit back once the Q beat of a pair has gone out.
module llr_fifo #(
    parameter int LLR_DW      = demod_pkg::LLR_DW_DEFAULT,
    parameter int FIFO_DEPTH  = flow_pkg::FIFO_DEPTH_DEFAULT,
    parameter int OUT_CREDITS = flow_pkg::OUT_CREDITS_DEFAULT
) (
    input  logic                           clk_i,
    input  logic                           reset_ni,

    // LLR pair from the demapper, written at the next edge
    input  logic                           pair_valid,
    input  logic signed [LLR_DW-1:0]       pair_llr_i,
    input  logic signed [LLR_DW-1:0]       pair_llr_q,
    input  logic [demod_pkg::TAG_W-1:0]    pair_tag,
    input  logic                           pair_last,

    // One pulse per beat consumed by the downstream buffer
    input  logic                           credit_return,

    // One pulse per pair freed, back to the upstream source
    output logic                           in_credit,

    // Serial beat stream
    output logic                           out_valid,
    output logic signed [LLR_DW-1:0]       out_llr,
    output logic [demod_pkg::TAG_W-1:0]    out_tag,
    output logic                           out_last
);

    import demod_pkg::*;
    import flow_pkg::*;

    // A depth of one still needs a one-bit pointer
    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    localparam logic [PTR_W-1:0]    LAST_IDX   = PTR_W'(FIFO_DEPTH - 1);
    localparam logic [CNT_W-1:0]    FULL_CNT   = CNT_W'(FIFO_DEPTH);
    localparam logic [CREDIT_W-1:0] CREDIT_MAX = CREDIT_W'(OUT_CREDITS);

    // Storage, one slot per pair
    logic signed [LLR_DW-1:0] mem_llr_i [FIFO_DEPTH];
    logic signed [LLR_DW-1:0] mem_llr_q [FIFO_DEPTH];
    logic [TAG_W-1:0]         mem_tag   [FIFO_DEPTH];
    logic                     mem_last  [FIFO_DEPTH];

    // Circular buffer bookkeeping
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] fill;
    logic             empty;
    logic             full;

    // Low while the I half of the head entry is next, high for the Q half
    logic             half_q;

    // Beats the downstream buffer can still take
    logic [CREDIT_W-1:0] out_credits;

    // Advance a pointer and wrap at the last slot, also for odd depths
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        if (ptr == LAST_IDX) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    assign empty = (fill == '0);
    assign full  = (fill == FULL_CNT);

    // A beat goes out in every cycle with data and at least one credit
    // There is no ready, the credit itself is the permission to send
    assign out_valid = !empty && (out_credits != '0);

    // Sending the Q half frees the head slot, which is also the input credit
    assign in_credit = out_valid && half_q;

    // Head entry, with the half select choosing the LLR
    assign out_llr  = half_q ? mem_llr_q[rd_ptr] : mem_llr_i[rd_ptr];
    assign out_tag  = mem_tag[rd_ptr];
    // The frame marker belongs to the Q beat only
    assign out_last = half_q && mem_last[rd_ptr];

    // Pair storage, written whole at the write pointer
    always_ff @(posedge clk_i) begin
        if (pair_valid) begin
            mem_llr_i[wr_ptr] <= pair_llr_i;
            mem_llr_q[wr_ptr] <= pair_llr_q;
            mem_tag[wr_ptr]   <= pair_tag;
            mem_last[wr_ptr]  <= pair_last;
        end
    end

    // Pointers and fill level
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (pair_valid) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (in_credit) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            // Write and free in the same cycle leave the fill unchanged
            case ({pair_valid, in_credit})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    // Half select toggles on every sent beat
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            half_q <= 1'b0;
        end else if (out_valid) begin
            half_q <= !half_q;
        end
    end

    // Output credits, spent per beat and regained per return pulse
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            out_credits <= CREDIT_MAX;
        end else begin
            case ({out_valid, credit_return})
                2'b10:   out_credits <= out_credits - 1'b1;
                2'b01:   out_credits <= out_credits + 1'b1;
                default: out_credits <= out_credits;
            endcase
        end
    end

    // Input credits guarantee space, so a write into a full buffer is a source error
    a_no_overflow : assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        pair_valid |-> !full
    ) else $error("llr_fifo: pair written while the buffer is full");

    // The sink can never return more credits than it was given at reset
    a_credit_bound : assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        out_credits <= CREDIT_MAX
    ) else $error("llr_fifo: output credits exceed %0d", OUT_CREDITS);

    // Spending the last credit with no return in flight must stall the next cycle
    a_credit_stall : assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        (out_valid && (out_credits == CREDIT_W'(1)) && !credit_return) |=> !out_valid
    ) else $error("llr_fifo: beat sent with zero output credits");

endmodule

// ==== qpsk_demap.sv ====
`timescale 1ns/1ns

// Hard-sliced soft demapper for QPSK.
// Each symbol gives one LLR for the I bit and one for the Q bit.
// The LLR is the top LLR_DW bits of the sample, so its sign follows the sample
// and a positive value favours bit 0.
module qpsk_demap #(
    parameter int IQ_DW  = demod_pkg::IQ_DW_DEFAULT,
    parameter int LLR_DW = demod_pkg::LLR_DW_DEFAULT
) (
    input  logic                           clk_i,
    input  logic                           reset_ni,

    // Symbol side, one symbol per cycle while in_valid is high
    input  logic                           in_valid,
    input  logic signed [IQ_DW-1:0]        in_i,
    input  logic signed [IQ_DW-1:0]        in_q,
    input  logic [demod_pkg::TAG_W-1:0]    in_tag,
    input  logic                           in_last,

    // LLR pair towards the buffer, one cycle after the symbol
    output logic                           pair_valid,
    output logic signed [LLR_DW-1:0]       pair_llr_i,
    output logic signed [LLR_DW-1:0]       pair_llr_q,
    output logic [demod_pkg::TAG_W-1:0]    pair_tag,
    output logic                           pair_last
);

    // Soft values taken straight from the sample MSBs
    logic signed [LLR_DW-1:0] llr_i;
    logic signed [LLR_DW-1:0] llr_q;

    // The slice itself is the LLR and is not scaled by noise variance
    assign llr_i = in_i[IQ_DW-1 -: LLR_DW];
    assign llr_q = in_q[IQ_DW-1 -: LLR_DW];

    // Valid flag follows in_valid one cycle later
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            pair_valid <= 1'b0;
        end else begin
            pair_valid <= in_valid;
        end
    end

    // Payload is loaded only with a valid symbol and holds otherwise
    always_ff @(posedge clk_i) begin
        if (in_valid) begin
            pair_llr_i <= llr_i;
            pair_llr_q <= llr_q;
            pair_tag   <= in_tag;
            pair_last  <= in_last;
        end
    end

    // The I and Q slices must fit in the sample they are cut from
    a_llr_width : assert property (
        @(posedge clk_i) LLR_DW <= IQ_DW / 2
    ) else $error("qpsk_demap: LLR_DW %0d exceeds half of IQ_DW %0d", LLR_DW, IQ_DW);

endmodule

// ==== flow_pkg.sv ====
// Flow control sizes for the LLR buffer and both credit loops.
// Kept apart from the datapath sizes because they describe the link, not the data.
package flow_pkg;

    // Number of LLR pairs the buffer holds.
    // The upstream source starts with this many input credits.
    localparam int FIFO_DEPTH_DEFAULT = 16;

    // Depth of the downstream buffer, counted in beats.
    // The output credit counter reloads to this value on reset.
    localparam int OUT_CREDITS_DEFAULT = 4;

    // Width of every credit counter in the design
    localparam int CREDIT_W = 8;

endpackage

// ==== demod_pkg.sv ====
// Sizes that describe the symbol and LLR datapath of the QPSK demapper.
// Every module that carries samples, LLRs or tags sizes its ports from here.
package demod_pkg;

    // Width of one I or Q sample as delivered by the front end.
    // Samples are two's complement, so the top bit is the sign.
    localparam int IQ_DW_DEFAULT = 16;

    // Width of one soft bit after demapping.
    // The LLR is cut from the top of the sample, so it keeps the sample sign.
    // It must not exceed half of IQ_DW_DEFAULT, which the demapper checks.
    localparam int LLR_DW_DEFAULT = 8;

    // Width of the per-symbol tag that rides along with both output beats.
    // The tag is opaque to the datapath and is only stored and replayed.
    localparam int TAG_W = 2;

endpackage
